// File: rtl/fpm_settings.svh
/*
	FPU exponent section settings
	widths of the exponent path and the mantissa length
*/

`ifndef FPM_SETTINGS_SVH
`define FPM_SETTINGS_SVH

// signed exponent as seen on the data bus
`define FPM_EXP_W 8
// adder width, exponent plus two guard bits
`define FPM_EXT_W 10
// mantissa length, a larger difference shifts the operand out
`define FPM_MANT_BITS 40
// alignment counter
`define FPM_CNT_W 6

`endif

// File: rtl/fpm_types_pkg.sv
/*
	FPU exponent section data types
	exponent, extended adder word and alignment count
*/

`default_nettype none

`include "fpm_settings.svh"

package fpm_types_pkg;

	// two's-complement exponent
	typedef logic signed [`FPM_EXP_W-1:0] exp_t;

	// adder word, sign-extended exponent with guard bits
	typedef logic signed [`FPM_EXT_W-1:0] exp_ext_t;

	// alignment shift count, low part of the difference
	typedef logic [`FPM_CNT_W-1:0] shift_cnt_t;

endpackage

`default_nettype wire

// File: rtl/fpm_ctrl_pkg.sv
/*
	FPU exponent section control encodings
	instruction field, adder bus mode, L bus select, sequencer states
*/

`default_nettype none

package fpm_ctrl_pkg;

	// instruction field ir, 0..3 fixed point, 4..7 floating point
	typedef logic [2:0] op_code_t;

	localparam op_code_t OP_AF = 3'd4;
	localparam op_code_t OP_SF = 3'd5;
	localparam op_code_t OP_MF = 3'd6;
	localparam op_code_t OP_DF = 3'd7;

	// how B enters the adder
	typedef enum logic {
		BUS_PASS,
		BUS_INV
	} bus_mode_t;

	// source of the D register load
	typedef enum logic [1:0] {
		LSEL_A,
		LSEL_B,
		LSEL_SUM,
		LSEL_MAX
	} lbus_sel_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD2,
		S_ADD,
		S_ALIGN,
		S_DONE
	} seq_state_t;

endpackage

`default_nettype wire

// File: rtl/fpm_decoder.sv
/*
	Instruction decoder
	one-of-eight decode of ir gated by pufa, class lines held per operation
*/

`timescale 1ns/1ps
`default_nettype none

module fpm_decoder
	import fpm_ctrl_pkg::*;
(
	input  wire      f2strob,
	input  wire      rst,
	input  wire      accept,
	input  op_code_t ir,
	input  wire      pufa,
	output logic     op_add,
	output logic     op_mul,
	output logic     op_div,
	output logic     is_float
);

	logic [7:0] line;
	logic [3:0] cls_live;
	logic [3:0] cls_q;

	// one line per instruction, all dark without pufa
	always_comb begin
		line = '0;
		if (pufa) begin
			line[ir] = 1'b1;
		end
	end

	// {add/sub, mul, div, any float}
	assign cls_live = {line[OP_AF] | line[OP_SF], line[OP_MF], line[OP_DF], pufa & ir[2]};

	always_ff @(posedge f2strob) begin
		if (rst) begin
			cls_q <= '0;
		end else if (accept) begin
			cls_q <= cls_live;
		end
	end

	// live decode during the accept cycle, so the first operand load
	// already knows the order, held value afterwards
	assign {op_add, op_mul, op_div, is_float} = accept ? cls_live : cls_q;

endmodule

`default_nettype wire

// File: rtl/fpm_exponent.sv
/*
	Exponent datapath
	D and B registers, B bus, 10-bit adder, range and alignment flags
*/

`timescale 1ns/1ps
`default_nettype none

`include "fpm_settings.svh"

module fpm_exponent
	import fpm_types_pkg::*, fpm_ctrl_pkg::*;
(
	input  wire        f2strob,
	input  wire        rst,
	input  exp_t       exp_a,
	input  exp_t       exp_b,
	input  lbus_sel_t  l_sel,
	input  wire        load_d,
	input  wire        load_b,
	input  bus_mode_t  bus_mode,
	input  wire        carry_in,
	input  wire        latch,
	input  wire        op_add,
	output logic       align_skip,
	output logic       wdt,
	output shift_cnt_t cnt_init,
	output logic       g,
	output logic       ovf,
	output logic       unf,
	output exp_t       exp_result
);

	exp_ext_t d_q;
	exp_t     b_q;
	exp_ext_t b_bus;
	exp_ext_t l_bus;
	exp_ext_t sum;
	exp_ext_t diff_mag;
	logic     sum_neg;
	logic     g_now;
	logic     ovf_now;
	logic     unf_now;

	function automatic exp_ext_t sext(input exp_t v);
		return {{(`FPM_EXT_W - `FPM_EXP_W){v[`FPM_EXP_W-1]}}, v};
	endfunction

	// B bus, true or inverted
	assign b_bus = (bus_mode == BUS_INV) ? ~sext(b_q) : sext(b_q);

	assign sum = d_q + b_bus + exp_ext_t'(carry_in);
	assign sum_neg = sum[`FPM_EXT_W-1];

	// alignment indicators
	assign diff_mag = sum_neg ? -sum : sum;
	assign g_now = diff_mag >= exp_ext_t'(`FPM_MANT_BITS);
	assign align_skip = (sum == '0) || g_now;
	assign cnt_init = sum[`FPM_CNT_W-1:0];

	// result leaves the 8-bit signed range when the guard bits disagree
	assign ovf_now = ~sum_neg & (sum[`FPM_EXT_W-2] | sum[`FPM_EXP_W-1]);
	assign unf_now = sum_neg & ~(sum[`FPM_EXT_W-2] & sum[`FPM_EXP_W-1]);

	// L bus into D
	always_comb begin
		case (l_sel)
			LSEL_A:   l_bus = sext(exp_a);
			LSEL_B:   l_bus = sext(exp_b);
			LSEL_SUM: l_bus = sum;
			// D still holds the second operand, B the first
			LSEL_MAX: l_bus = sum_neg ? sext(b_q) : d_q;
			default:  l_bus = sum;
		endcase
	end

	always_ff @(posedge f2strob) begin
		if (rst) begin
			d_q <= '0;
		end else if (load_d) begin
			d_q <= l_bus;
		end
	end

	always_ff @(posedge f2strob) begin
		if (load_b) begin
			b_q <= d_q[`FPM_EXP_W-1:0];
		end
	end

	// flags follow the operation that was latched last
	always_ff @(posedge f2strob) begin
		if (rst) begin
			g   <= 1'b0;
			wdt <= 1'b0;
			ovf <= 1'b0;
			unf <= 1'b0;
		end else if (latch) begin
			if (op_add) begin
				g   <= g_now;
				wdt <= sum_neg;
				ovf <= 1'b0;
				unf <= 1'b0;
			end else begin
				g   <= 1'b0;
				wdt <= 1'b0;
				ovf <= ovf_now;
				unf <= unf_now;
			end
		end
	end

	assign exp_result = d_q[`FPM_EXP_W-1:0];

endmodule

`default_nettype wire

// File: rtl/fpm_shift_counter.sv
/*
	Alignment shift counter
	loads the low part of the difference and counts toward zero
*/

`timescale 1ns/1ps
`default_nettype none

module fpm_shift_counter
	import fpm_types_pkg::*;
(
	input  wire        f2strob,
	input  wire        rst,
	input  wire        load,
	input  shift_cnt_t init,
	input  wire        up,
	input  wire        step,
	output logic       cnt_last
);

	shift_cnt_t cnt_q;

	// negative difference is loaded as its two's complement,
	// counting up wraps it to zero after the same number of steps
	always_ff @(posedge f2strob) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (load) begin
			cnt_q <= init;
		end else if (step) begin
			if (up) begin
				cnt_q <= cnt_q + shift_cnt_t'(1);
			end else begin
				cnt_q <= cnt_q - shift_cnt_t'(1);
			end
		end
	end

	// one step from zero in the current direction
	always_comb begin
		if (up) begin
			cnt_last = (cnt_q == '1);
		end else begin
			cnt_last = (cnt_q == shift_cnt_t'(1));
		end
	end

endmodule

`default_nettype wire

// File: rtl/fpm_sequencer.sv
/*
	Microoperation sequencer
	walks the operand load, add and alignment phases of AF, SF, MF and DF
*/

`timescale 1ns/1ps
`default_nettype none

module fpm_sequencer
	import fpm_ctrl_pkg::*;
(
	input  wire       f2strob,
	input  wire       rst,
	input  wire       start,
	input  wire       is_float,
	input  wire       op_add,
	input  wire       op_mul,
	input  wire       op_div,
	input  wire       align_skip,
	input  wire       wdt,
	input  wire       cnt_last,
	output logic      accept,
	output logic      busy,
	output logic      done,
	output logic      reject,
	output lbus_sel_t l_sel,
	output logic      load_d,
	output logic      load_b,
	output bus_mode_t bus_mode,
	output logic      carry_in,
	output logic      latch,
	output logic      cnt_load,
	output logic      cnt_step,
	output logic      shift_t,
	output logic      shift_c
);

	seq_state_t state;
	seq_state_t state_nx;

	assign accept = start && (state == S_IDLE);
	assign busy = (state != S_IDLE);
	assign done = (state == S_DONE);
	assign reject = done && !is_float;

	always_comb begin
		state_nx = state;
		l_sel    = LSEL_A;
		load_d   = 1'b0;
		load_b   = 1'b0;
		bus_mode = BUS_INV;
		carry_in = 1'b1;
		latch    = 1'b0;
		cnt_load = 1'b0;
		cnt_step = 1'b0;
		shift_t  = 1'b0;
		shift_c  = 1'b0;
		case (state)
			S_IDLE: begin
				// first operand, exp_b first for divide
				if (accept) begin
					l_sel    = op_div ? LSEL_B : LSEL_A;
					load_d   = is_float;
					state_nx = S_LOAD2;
				end
			end
			S_LOAD2: begin
				if (is_float) begin
					l_sel    = op_div ? LSEL_A : LSEL_B;
					load_d   = 1'b1;
					load_b   = 1'b1;
					state_nx = S_ADD;
				end else begin
					state_nx = S_DONE;
				end
			end
			S_ADD: begin
				// D + B for multiply, D - B otherwise
				bus_mode = op_mul ? BUS_PASS : BUS_INV;
				carry_in = !op_mul;
				latch    = 1'b1;
				load_d   = 1'b1;
				l_sel    = op_add ? LSEL_MAX : LSEL_SUM;
				cnt_load = op_add;
				state_nx = (op_add && !align_skip) ? S_ALIGN : S_DONE;
			end
			S_ALIGN: begin
				cnt_step = 1'b1;
				shift_t  = !wdt;
				shift_c  = wdt;
				if (cnt_last) begin
					state_nx = S_DONE;
				end
			end
			S_DONE: begin
				state_nx = S_IDLE;
			end
			default: begin
				state_nx = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge f2strob) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			state <= state_nx;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fpm_top.sv
/*
	FPU exponent and control section
	decoder, exponent datapath, shift counter and sequencer
*/

`timescale 1ns/1ps
`default_nettype none

module fpm_top
	import fpm_types_pkg::*, fpm_ctrl_pkg::*;
(
	input  wire      f2strob,
	input  wire      rst,
	input  wire      start,
	input  op_code_t ir,
	input  wire      pufa,
	input  exp_t     exp_a,
	input  exp_t     exp_b,
	output logic     busy,
	output logic     done,
	output logic     reject,
	output exp_t     exp_result,
	output logic     g,
	output logic     wdt,
	output logic     ovf,
	output logic     unf,
	output logic     shift_t,
	output logic     shift_c
);

	logic       accept;
	logic       op_add;
	logic       op_mul;
	logic       op_div;
	logic       is_float;
	lbus_sel_t  l_sel;
	logic       load_d;
	logic       load_b;
	bus_mode_t  bus_mode;
	logic       carry_in;
	logic       latch;
	logic       align_skip;
	shift_cnt_t cnt_init;
	logic       cnt_load;
	logic       cnt_step;
	logic       cnt_last;

	fpm_decoder u_decoder (
		.f2strob  (f2strob),
		.rst      (rst),
		.accept   (accept),
		.ir       (ir),
		.pufa     (pufa),
		.op_add   (op_add),
		.op_mul   (op_mul),
		.op_div   (op_div),
		.is_float (is_float)
	);

	fpm_exponent u_exponent (
		.f2strob    (f2strob),
		.rst        (rst),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.l_sel      (l_sel),
		.load_d     (load_d),
		.load_b     (load_b),
		.bus_mode   (bus_mode),
		.carry_in   (carry_in),
		.latch      (latch),
		.op_add     (op_add),
		.align_skip (align_skip),
		.wdt        (wdt),
		.cnt_init   (cnt_init),
		.g          (g),
		.ovf        (ovf),
		.unf        (unf),
		.exp_result (exp_result)
	);

	// direction follows the latched wdt
	fpm_shift_counter u_shift_counter (
		.f2strob  (f2strob),
		.rst      (rst),
		.load     (cnt_load),
		.init     (cnt_init),
		.up       (wdt),
		.step     (cnt_step),
		.cnt_last (cnt_last)
	);

	fpm_sequencer u_sequencer (
		.f2strob    (f2strob),
		.rst        (rst),
		.start      (start),
		.is_float   (is_float),
		.op_add     (op_add),
		.op_mul     (op_mul),
		.op_div     (op_div),
		.align_skip (align_skip),
		.wdt        (wdt),
		.cnt_last   (cnt_last),
		.accept     (accept),
		.busy       (busy),
		.done       (done),
		.reject     (reject),
		.l_sel      (l_sel),
		.load_d     (load_d),
		.load_b     (load_b),
		.bus_mode   (bus_mode),
		.carry_in   (carry_in),
		.latch      (latch),
		.cnt_load   (cnt_load),
		.cnt_step   (cnt_step),
		.shift_t    (shift_t),
		.shift_c    (shift_c)
	);

endmodule

`default_nettype wire

// File: dv/fpm_chk.sv
/*
	Protocol checker for the exponent section
	concurrent properties on done, reject and the shift pulses
*/

`timescale 1ns/1ps
`default_nettype none

module fpm_chk (
	input wire f2strob,
	input wire rst,
	input wire busy,
	input wire done,
	input wire reject,
	input wire shift_t,
	input wire shift_c
);

	// bumped on every failed property, watched from the testbench
	int unsigned fail_count = 0;

	a_done_single: assert property (@(posedge f2strob) disable iff (rst)
		done |=> !done)
	else begin
		$error("done stayed high for more than one cycle");
		fail_count++;
	end

	// one operand direction at a time
	a_shift_excl: assert property (@(posedge f2strob) disable iff (rst)
		!(shift_t && shift_c))
	else begin
		$error("shift_t and shift_c high together");
		fail_count++;
	end

	a_shift_not_done: assert property (@(posedge f2strob) disable iff (rst)
		!((shift_t || shift_c) && done))
	else begin
		$error("shift pulse in the done cycle");
		fail_count++;
	end

	a_shift_busy: assert property (@(posedge f2strob) disable iff (rst)
		(shift_t || shift_c) |-> busy)
	else begin
		$error("shift pulse outside busy");
		fail_count++;
	end

	a_reject_done: assert property (@(posedge f2strob) disable iff (rst)
		reject |-> done)
	else begin
		$error("reject without done");
		fail_count++;
	end

endmodule

bind fpm_top fpm_chk u_chk (
	.f2strob (f2strob),
	.rst     (rst),
	.busy    (busy),
	.done    (done),
	.reject  (reject),
	.shift_t (shift_t),
	.shift_c (shift_c)
);

`default_nettype wire

// File: dv/fpm_tb.sv
/*
	Testbench for the FPU exponent section
	random AF/SF/MF/DF and fixed-point requests against a reference model
*/

`timescale 1ns/1ps
`default_nettype none

`include "fpm_settings.svh"

module fpm_tb
	import fpm_types_pkg::*, fpm_ctrl_pkg::*;
();

	localparam int N_REQ = 300;
	localparam int CYCLE_LIMIT = N_REQ * 48 + 100;

	logic     f2strob;
	logic     rst;
	logic     start;
	op_code_t ir;
	logic     pufa;
	exp_t     exp_a;
	exp_t     exp_b;
	logic     busy;
	logic     done;
	logic     reject;
	exp_t     exp_result;
	logic     g;
	logic     wdt;
	logic     ovf;
	logic     unf;
	logic     shift_t;
	logic     shift_c;

	// model state, held across rejected requests
	exp_t m_result;
	logic m_g;
	logic m_wdt;
	logic m_ovf;
	logic m_unf;
	// per-request expectations
	logic e_float;
	int   e_n;
	int   e_lat;
	int   cycle_count;

	fpm_top uut (
		.f2strob    (f2strob),
		.rst        (rst),
		.start      (start),
		.ir         (ir),
		.pufa       (pufa),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.busy       (busy),
		.done       (done),
		.reject     (reject),
		.exp_result (exp_result),
		.g          (g),
		.wdt        (wdt),
		.ovf        (ovf),
		.unf        (unf),
		.shift_t    (shift_t),
		.shift_c    (shift_c)
	);

	initial begin
		f2strob = 1'b0;
		forever #2 f2strob = ~f2strob;
	end

	task automatic report_failure();
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_exp(input string name, input exp_t got, input exp_t expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h expected %h", name, got, expected);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h expected %h", name, got, expected);
			report_failure();
		end
	endtask

	task automatic check_count(input string name, input shift_cnt_t got,
		input shift_cnt_t expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h expected %h", name, got, expected);
			report_failure();
		end
	endtask

	// mostly float codes, a quarter with a small exponent difference
	task automatic choose_request();
		int off;
		ir = op_code_t'($urandom_range(7, 0));
		if ($urandom_range(3, 0) != 0) begin
			ir[2] = 1'b1;
		end
		pufa = ($urandom_range(9, 0) != 0);
		exp_a = exp_t'($urandom_range(255, 0));
		exp_b = exp_t'($urandom_range(255, 0));
		if ($urandom_range(3, 0) == 0) begin
			off = int'($urandom_range(78, 0)) - 39;
			if (int'(exp_a) + off > 127 || int'(exp_a) + off < -128) begin
				off = -off;
			end
			exp_b = exp_t'(int'(exp_a) + off);
		end
	endtask

	task automatic predict();
		int ai;
		int bi;
		int d;
		int mag;
		ai = int'(exp_a);
		bi = int'(exp_b);
		e_float = pufa && ir[2];
		e_n = 0;
		e_lat = 1;
		if (e_float) begin
			if (ir == OP_AF || ir == OP_SF) begin
				d = bi - ai;
				mag = (d < 0) ? -d : d;
				m_result = (bi >= ai) ? exp_b : exp_a;
				m_wdt = (d < 0);
				m_g = (mag >= `FPM_MANT_BITS);
				m_ovf = 1'b0;
				m_unf = 1'b0;
				if (!m_g) begin
					e_n = mag;
				end
			end else begin
				d = (ir == OP_MF) ? ai + bi : ai - bi;
				m_result = exp_t'(d);
				m_g = 1'b0;
				m_wdt = 1'b0;
				m_ovf = (d > 127);
				m_unf = (d < -128);
			end
			e_lat = 2 + e_n;
		end
	endtask

	// start may stay high into busy, dropped by done at the latest
	task automatic run_request();
		int hold;
		int waited;
		int t_pulses;
		int c_pulses;
		hold = $urandom_range(4, 0);
		waited = 0;
		t_pulses = 0;
		c_pulses = 0;
		predict();
		start = 1'b1;
		do begin
			@(negedge f2strob);
			if (waited == 0) begin
				check_flag("busy", busy, 1'b1);
			end
			if (shift_t) begin
				t_pulses++;
			end
			if (shift_c) begin
				c_pulses++;
			end
			if (waited >= hold || done) begin
				start = 1'b0;
			end
			waited++;
		end while (!done);
		check_count("done latency", shift_cnt_t'(waited - 1), shift_cnt_t'(e_lat));
		check_flag("reject", reject, !e_float);
		check_exp("exp_result", exp_result, m_result);
		check_flag("g", g, m_g);
		check_flag("wdt", wdt, m_wdt);
		check_flag("ovf", ovf, m_ovf);
		check_flag("unf", unf, m_unf);
		check_count("shift_t pulses", shift_cnt_t'(t_pulses), shift_cnt_t'(m_wdt ? 0 : e_n));
		check_count("shift_c pulses", shift_cnt_t'(c_pulses), shift_cnt_t'(m_wdt ? e_n : 0));
		@(negedge f2strob);
		check_flag("busy after done", busy, 1'b0);
		check_flag("done after done", done, 1'b0);
		repeat ($urandom_range(2, 0)) @(negedge f2strob);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge f2strob);
			cycle_count++;
		end
		$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		report_failure();
	end

	always @(negedge f2strob) begin
		if (uut.u_chk.fail_count != 0) begin
			$display("a protocol assertion in the checker failed");
			report_failure();
		end
	end

	initial begin
		void'($urandom(69));
		rst = 1'b1;
		start = 1'b0;
		ir = '0;
		pufa = 1'b0;
		exp_a = '0;
		exp_b = '0;
		m_result = '0;
		m_g = 1'b0;
		m_wdt = 1'b0;
		m_ovf = 1'b0;
		m_unf = 1'b0;
		repeat (16) @(negedge f2strob);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("reject", reject, 1'b0);
		check_flag("shift_t", shift_t, 1'b0);
		check_flag("shift_c", shift_c, 1'b0);
		check_flag("g", g, 1'b0);
		check_flag("wdt", wdt, 1'b0);
		check_flag("ovf", ovf, 1'b0);
		check_flag("unf", unf, 1'b0);
		check_exp("exp_result", exp_result, '0);
		rst = 1'b0;
		for (int i = 0; i < N_REQ; i++) begin
			choose_request();
			run_request();
		end
		if (uut.u_chk.fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("a protocol assertion in the checker failed");
			report_failure();
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fpm_top.f
+incdir+rtl
rtl/fpm_types_pkg.sv
rtl/fpm_ctrl_pkg.sv
rtl/fpm_decoder.sv
rtl/fpm_exponent.sv
rtl/fpm_shift_counter.sv
rtl/fpm_sequencer.sv
rtl/fpm_top.sv
dv/fpm_chk.sv
dv/fpm_tb.sv

// File: Makefile
# Verilator build and run for the FPU exponent section

VERILATOR ?= verilator
TOP       ?= fpm_tb
FILELIST  ?= fpm_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv) $(FILELIST)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, the simulator exit code alone does not
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
